//--- logic/ptw_pkg.sv
/*
 * Sv39 widths and the types shared by the walker and its TLB clients.
 * The ASID field of a TLB update is sized for the widest supported ASID.
 * Narrower ASIDs arrive zero-extended.
 */

package ptw_pkg;

    // --------------------------------------------------
    // Sv39 geometry
    // --------------------------------------------------
    localparam int VLEN          = 39;
    localparam int PLEN          = 56;
    localparam int PPN_W         = 44;
    localparam int VPN_W         = 9;
    localparam int PAGE_OFFSET_W = 12;
    localparam int PTE_SIZE_LOG2 = 3;
    localparam int ASID_W_MAX    = 16;

    // 64-bit page table entry, flags in the low byte
    typedef struct packed {
        logic [9:0]       reserved;
        logic [PPN_W-1:0] ppn;
        logic [1:0]       rsw;
        logic             d;
        logic             a;
        logic             g;
        logic             u;
        logic             x;
        logic             w;
        logic             r;
        logic             v;
    } pte_t;

    // LVL1 is the root table that maps 1G pages
    typedef enum logic [1:0] {
        LVL1,
        LVL2,
        LVL3
    } ptw_level_e;

    // --------------------------------------------------
    // TLB update
    // --------------------------------------------------
    // content carries the leaf with g folded over the whole walk
    typedef struct packed {
        logic                          valid;
        logic                          is_1g;
        logic                          is_2m;
        logic [VLEN-PAGE_OFFSET_W-1:0] vpn;
        logic [ASID_W_MAX-1:0]         asid;
        pte_t                          content;
    } tlb_update_t;

endpackage

//--- logic/walk_req_if.sv
/*
 * Walk request from the miss arbiter to the walk controller.
 * start is a one-cycle pulse and only comes while busy is low.
 * vaddr and asid stay valid until the next start.
 */

`timescale 1ns/1ps

interface walk_req_if import ptw_pkg::*; #(
    parameter int ASID_WIDTH = 16
) ();

    logic                  start;
    logic                  is_instr;
    logic [VLEN-1:0]       vaddr;
    logic [PLEN-1:0]       root_pptr;
    logic [ASID_WIDTH-1:0] asid;
    // high whenever the controller is outside idle
    logic                  busy;

    modport arbiter (
        output start, is_instr, vaddr, root_pptr, asid,
        input  busy
    );

    modport controller (
        input  start, is_instr, vaddr, root_pptr, asid,
        output busy
    );

endinterface

//--- logic/tlb_miss_arbiter.sv
/*
 * Picks one TLB miss per walk, data side first.
 * Miss strobes and start are registered, so they pulse one cycle
 * after the TLB lookup that missed.
 */

`timescale 1ns/1ps

module tlb_miss_arbiter import ptw_pkg::*; #(
    parameter int ASID_WIDTH = 16
) (
    input  logic                  clk_i,
    input  logic                  rst_ni,
    input  logic                  enable_translation_i,
    input  logic                  en_ld_st_translation_i,
    input  logic                  itlb_access_i,
    input  logic                  itlb_hit_i,
    input  logic [VLEN-1:0]       itlb_vaddr_i,
    input  logic                  dtlb_access_i,
    input  logic                  dtlb_hit_i,
    input  logic [VLEN-1:0]       dtlb_vaddr_i,
    input  logic [PPN_W-1:0]      satp_ppn_i,
    input  logic [ASID_WIDTH-1:0] asid_i,
    output logic                  itlb_miss_o,
    output logic                  dtlb_miss_o,
    walk_req_if.arbiter           req
);

    logic                  start_q;
    logic                  itlb_miss_q;
    logic                  dtlb_miss_q;
    logic                  is_instr_q;
    logic [VLEN-1:0]       vaddr_q;
    logic [ASID_WIDTH-1:0] asid_q;
    logic [PLEN-1:0]       root_q;
    logic                  can_start;
    logic                  dtlb_miss;
    logic                  itlb_miss;
    logic [VLEN-1:0]       miss_vaddr;

    // the controller is still idle during the start pulse
    assign can_start = !req.busy && !start_q;

    assign dtlb_miss = can_start && en_ld_st_translation_i && dtlb_access_i && !dtlb_hit_i;
    // an instruction walk yields to any data access
    assign itlb_miss = can_start && enable_translation_i && itlb_access_i && !itlb_hit_i
                       && !dtlb_access_i;

    assign miss_vaddr = dtlb_miss ? dtlb_vaddr_i : itlb_vaddr_i;

    always_ff @(posedge clk_i or negedge rst_ni) begin
        if (!rst_ni) begin
            start_q     <= 1'b0;
            itlb_miss_q <= 1'b0;
            dtlb_miss_q <= 1'b0;
            is_instr_q  <= 1'b0;
        end else begin
            start_q     <= dtlb_miss || itlb_miss;
            itlb_miss_q <= itlb_miss;
            dtlb_miss_q <= dtlb_miss;
            if (dtlb_miss || itlb_miss) begin
                is_instr_q <= itlb_miss;
            end
        end
    end

    // root pointer indexes the 1G table with vpn[2]
    always_ff @(posedge clk_i) begin
        if (dtlb_miss || itlb_miss) begin
            vaddr_q <= miss_vaddr;
            asid_q  <= asid_i;
            root_q  <= {satp_ppn_i, miss_vaddr[VLEN-1 -: VPN_W], {PTE_SIZE_LOG2{1'b0}}};
        end
    end

    assign req.start     = start_q;
    assign req.is_instr  = is_instr_q;
    assign req.vaddr     = vaddr_q;
    assign req.asid      = asid_q;
    assign req.root_pptr = root_q;

    assign itlb_miss_o = itlb_miss_q;
    assign dtlb_miss_o = dtlb_miss_q;

endmodule

//--- logic/pte_checker.sv
/*
 * Classifies one returned PTE at the given level.
 * Exactly one of pointer, good leaf or fault is high.
 * A and D are managed by software, so a missing bit is a fault.
 */

`timescale 1ns/1ps

module pte_checker import ptw_pkg::*; (
    input  pte_t       pte_i,
    input  ptw_level_e level_i,
    input  logic       is_instr_i,
    input  logic       is_store_i,
    input  logic       mxr_i,
    output logic       is_pointer_o,
    output logic       leaf_ok_o,
    output logic       fault_o
);

    logic invalid;
    logic is_leaf;
    logic instr_ok;
    logic data_ok;
    logic perm_ok;
    logic misaligned;

    // v clear, or write without read, is reserved
    assign invalid = !pte_i.v || (pte_i.w && !pte_i.r);
    assign is_leaf = pte_i.r || pte_i.x;

    // --------------------------------------------------
    // permissions
    // --------------------------------------------------
    assign instr_ok = pte_i.x && pte_i.a;

    // mxr lets loads read execute-only pages
    assign data_ok = pte_i.a && (pte_i.r || (pte_i.x && mxr_i))
                     && (!is_store_i || (pte_i.w && pte_i.d));

    assign perm_ok = is_instr_i ? instr_ok : data_ok;

    // superpages need the low ppn slices clear
    always_comb begin
        case (level_i)
            LVL1:    misaligned = pte_i.ppn[2*VPN_W-1:0] != '0;
            LVL2:    misaligned = pte_i.ppn[VPN_W-1:0] != '0;
            default: misaligned = 1'b0;
        endcase
    end

    // a pointer at the last level has nowhere to go
    assign is_pointer_o = !invalid && !is_leaf && (level_i != LVL3);
    assign leaf_ok_o    = !invalid && is_leaf && perm_ok && !misaligned;
    assign fault_o      = !is_pointer_o && !leaf_ok_o;

endmodule

//--- logic/walk_controller.sv
/*
 * Sv39 walk FSM with one outstanding PTE read at a time.
 * The response is registered on input and judged a cycle later.
 * On flush a granted read is still waited for before idle.
 */

`timescale 1ns/1ps

module walk_controller import ptw_pkg::*; (
    input  logic            clk_i,
    input  logic            rst_ni,
    input  logic            flush_i,
    input  logic            lsu_is_store_i,
    input  logic            mxr_i,
    output logic            mem_req_o,
    output logic [PLEN-1:0] mem_addr_o,
    input  logic            mem_gnt_i,
    input  logic            mem_rvalid_i,
    input  logic [63:0]     mem_rdata_i,
    output tlb_update_t     itlb_update_o,
    output tlb_update_t     dtlb_update_o,
    output logic [VLEN-1:0] update_vaddr_o,
    output logic            ptw_active_o,
    output logic            walking_instr_o,
    output logic            ptw_error_o,
    walk_req_if.controller  req
);

    typedef enum logic [2:0] {
        S_IDLE,
        S_WAIT_GRANT,
        S_LOOKUP,
        S_WAIT_RVALID,
        S_ERROR
    } state_e;

    state_e           state_q, state_d;
    ptw_level_e       level_q, level_d;
    logic [PLEN-1:0]  pptr_q, pptr_d;
    logic             global_q, global_d;
    logic             is_instr_q, is_instr_d;
    logic             rvalid_q;
    logic [63:0]      rdata_q;
    pte_t             pte;
    logic             is_pointer;
    logic             leaf_ok;
    logic             fault;
    logic [VPN_W-1:0] next_vpn;
    tlb_update_t      update;

    assign pte = pte_t'(rdata_q);

    pte_checker u_pte_checker (
        .pte_i        (pte),
        .level_i      (level_q),
        .is_instr_i   (is_instr_q),
        .is_store_i   (lsu_is_store_i),
        .mxr_i        (mxr_i),
        .is_pointer_o (is_pointer),
        .leaf_ok_o    (leaf_ok),
        .fault_o      (fault)
    );

    // vpn[1] after the root, vpn[0] after that
    assign next_vpn = (level_q == LVL1) ? req.vaddr[PAGE_OFFSET_W+VPN_W +: VPN_W]
                                        : req.vaddr[PAGE_OFFSET_W +: VPN_W];

    // --------------------------------------------------
    // TLB update
    // --------------------------------------------------
    always_comb begin
        update           = '0;
        update.valid     = (state_q == S_LOOKUP) && rvalid_q && leaf_ok && !flush_i;
        update.is_1g     = (level_q == LVL1);
        update.is_2m     = (level_q == LVL2);
        update.vpn       = req.vaddr[VLEN-1:PAGE_OFFSET_W];
        update.asid      = ASID_W_MAX'(req.asid);
        update.content   = pte;
        update.content.g = pte.g || global_q;
        itlb_update_o       = update;
        itlb_update_o.valid = update.valid && is_instr_q;
        dtlb_update_o       = update;
        dtlb_update_o.valid = update.valid && !is_instr_q;
    end

    // --------------------------------------------------
    // walk FSM
    // --------------------------------------------------
    always_comb begin
        state_d    = state_q;
        level_d    = level_q;
        pptr_d     = pptr_q;
        global_d   = global_q;
        is_instr_d = is_instr_q;
        case (state_q)
            S_IDLE: begin
                if (req.start) begin
                    level_d    = LVL1;
                    pptr_d     = req.root_pptr;
                    global_d   = 1'b0;
                    is_instr_d = req.is_instr;
                    state_d    = S_WAIT_GRANT;
                end
            end
            S_WAIT_GRANT: begin
                if (mem_gnt_i) begin
                    state_d = S_LOOKUP;
                end
            end
            S_LOOKUP: begin
                if (rvalid_q) begin
                    global_d = global_q || pte.g;
                    if (is_pointer) begin
                        level_d = (level_q == LVL1) ? LVL2 : LVL3;
                        pptr_d  = {pte.ppn, next_vpn, {PTE_SIZE_LOG2{1'b0}}};
                        state_d = S_WAIT_GRANT;
                    end else if (fault) begin
                        state_d = S_ERROR;
                    end else begin
                        state_d = S_IDLE;
                    end
                end
            end
            S_WAIT_RVALID: begin
                if (rvalid_q) begin
                    state_d = S_IDLE;
                end
            end
            default: state_d = S_IDLE;
        endcase
        // a read already granted must still drain
        if (flush_i) begin
            if ((state_q == S_LOOKUP && !rvalid_q) || (state_q == S_WAIT_GRANT && mem_gnt_i)) begin
                state_d = S_WAIT_RVALID;
            end else begin
                state_d = S_IDLE;
            end
        end
    end

    always_ff @(posedge clk_i or negedge rst_ni) begin
        if (!rst_ni) begin
            state_q    <= S_IDLE;
            level_q    <= LVL1;
            global_q   <= 1'b0;
            is_instr_q <= 1'b0;
            rvalid_q   <= 1'b0;
        end else begin
            state_q    <= state_d;
            level_q    <= level_d;
            global_q   <= global_d;
            is_instr_q <= is_instr_d;
            rvalid_q   <= mem_rvalid_i;
        end
    end

    always_ff @(posedge clk_i) begin
        pptr_q  <= pptr_d;
        rdata_q <= mem_rdata_i;
    end

    assign mem_req_o       = (state_q == S_WAIT_GRANT);
    assign mem_addr_o      = pptr_q;
    assign ptw_error_o     = (state_q == S_ERROR) && !flush_i;
    assign ptw_active_o    = (state_q != S_IDLE);
    assign req.busy        = (state_q != S_IDLE);
    assign walking_instr_o = is_instr_q;
    assign update_vaddr_o  = req.vaddr;

endmodule

//--- logic/page_table_walker.sv
/*
 * Sv39 page table walker for one ITLB and one DTLB.
 * Single-stage translation only, no PMP check on PTE reads.
 * ASID_WIDTH may be at most 16.
 */

`timescale 1ns/1ps

module page_table_walker import ptw_pkg::*; #(
    parameter int ASID_WIDTH = 16
) (
    input  logic                  clk_i,
    input  logic                  rst_ni,
    input  logic                  flush_i,
    input  logic                  enable_translation_i,
    input  logic                  en_ld_st_translation_i,
    input  logic                  lsu_is_store_i,
    input  logic                  mxr_i,
    input  logic [PPN_W-1:0]      satp_ppn_i,
    input  logic [ASID_WIDTH-1:0] asid_i,
    // TLB lookups
    input  logic                  itlb_access_i,
    input  logic                  itlb_hit_i,
    input  logic [VLEN-1:0]       itlb_vaddr_i,
    input  logic                  dtlb_access_i,
    input  logic                  dtlb_hit_i,
    input  logic [VLEN-1:0]       dtlb_vaddr_i,
    // PTE read port
    output logic                  mem_req_o,
    output logic [PLEN-1:0]       mem_addr_o,
    input  logic                  mem_gnt_i,
    input  logic                  mem_rvalid_i,
    input  logic [63:0]           mem_rdata_i,
    // results
    output tlb_update_t           itlb_update_o,
    output tlb_update_t           dtlb_update_o,
    output logic [VLEN-1:0]       update_vaddr_o,
    output logic                  ptw_active_o,
    output logic                  walking_instr_o,
    output logic                  ptw_error_o,
    output logic                  itlb_miss_o,
    output logic                  dtlb_miss_o
);

    walk_req_if #(.ASID_WIDTH(ASID_WIDTH)) walk_req ();

    tlb_miss_arbiter #(
        .ASID_WIDTH (ASID_WIDTH)
    ) u_arbiter (
        .clk_i                  (clk_i),
        .rst_ni                 (rst_ni),
        .enable_translation_i   (enable_translation_i),
        .en_ld_st_translation_i (en_ld_st_translation_i),
        .itlb_access_i          (itlb_access_i),
        .itlb_hit_i             (itlb_hit_i),
        .itlb_vaddr_i           (itlb_vaddr_i),
        .dtlb_access_i          (dtlb_access_i),
        .dtlb_hit_i             (dtlb_hit_i),
        .dtlb_vaddr_i           (dtlb_vaddr_i),
        .satp_ppn_i             (satp_ppn_i),
        .asid_i                 (asid_i),
        .itlb_miss_o            (itlb_miss_o),
        .dtlb_miss_o            (dtlb_miss_o),
        .req                    (walk_req.arbiter)
    );

    walk_controller u_controller (
        .clk_i           (clk_i),
        .rst_ni          (rst_ni),
        .flush_i         (flush_i),
        .lsu_is_store_i  (lsu_is_store_i),
        .mxr_i           (mxr_i),
        .mem_req_o       (mem_req_o),
        .mem_addr_o      (mem_addr_o),
        .mem_gnt_i       (mem_gnt_i),
        .mem_rvalid_i    (mem_rvalid_i),
        .mem_rdata_i     (mem_rdata_i),
        .itlb_update_o   (itlb_update_o),
        .dtlb_update_o   (dtlb_update_o),
        .update_vaddr_o  (update_vaddr_o),
        .ptw_active_o    (ptw_active_o),
        .walking_instr_o (walking_instr_o),
        .ptw_error_o     (ptw_error_o),
        .req             (walk_req.controller)
    );

endmodule

//--- bench/page_table_walker_asserts.sv
/*
 * Bound checks on the PTE read port and the result strobes.
 * A flush may drop a request that was not yet granted.
 */

`timescale 1ns/1ps

module page_table_walker_asserts import ptw_pkg::*; (
    input logic            clk_i,
    input logic            rst_ni,
    input logic            flush_i,
    input logic            mem_req_o,
    input logic            mem_gnt_i,
    input logic [PLEN-1:0] mem_addr_o,
    input tlb_update_t     itlb_update_o,
    input tlb_update_t     dtlb_update_o,
    input logic            ptw_error_o
);

    // request and address hold until granted
    a_req_hold: assert property (@(posedge clk_i) disable iff (!rst_ni)
        mem_req_o && !mem_gnt_i && !flush_i |=> mem_req_o && $stable(mem_addr_o))
        else $error("mem_req_o dropped before grant");

    a_update_vs_error: assert property (@(posedge clk_i) disable iff (!rst_ni)
        !((itlb_update_o.valid || dtlb_update_o.valid) && ptw_error_o))
        else $error("update and page fault in one cycle");

    a_one_tlb: assert property (@(posedge clk_i) disable iff (!rst_ni)
        !(itlb_update_o.valid && dtlb_update_o.valid))
        else $error("both TLB updates valid");

endmodule

//--- bench/tb_page_table_walker.sv
/*
 * Testbench for the Sv39 walker with a random-latency PTE memory.
 * Unmapped PTE addresses read as zero, i.e. an invalid entry.
 */

`timescale 1ns/1ps

module tb_page_table_walker import ptw_pkg::*;;

    localparam int NUM_WALKS  = 16;
    localparam int MAX_CYCLES = 40 * NUM_WALKS;
    localparam logic [PPN_W-1:0] ROOT = 44'h80;
    // flag bits in the low byte of a PTE
    localparam logic [7:0] V = 8'h01, R = 8'h02, W = 8'h04, X = 8'h08;
    localparam logic [7:0] G = 8'h20, A = 8'h40, D = 8'h80;

    logic clk_i = 1'b0, rst_ni, flush_i, enable_translation_i, en_ld_st_translation_i;
    logic lsu_is_store_i, mxr_i, itlb_access_i, itlb_hit_i, dtlb_access_i, dtlb_hit_i;
    logic [PPN_W-1:0] satp_ppn_i;
    logic [15:0]      asid_i;
    logic [VLEN-1:0]  itlb_vaddr_i, dtlb_vaddr_i, update_vaddr_o;
    logic mem_req_o, mem_gnt_i, mem_rvalid_i, ptw_active_o, walking_instr_o;
    logic ptw_error_o, itlb_miss_o, dtlb_miss_o;
    logic [PLEN-1:0]  mem_addr_o;
    logic [63:0]      mem_rdata_i;
    tlb_update_t      itlb_update_o, dtlb_update_o;

    logic [63:0] pt_mem [logic [PLEN-1:0]];
    string       exp_names[$];
    tlb_update_t exp_updates[$];
    bit          exp_faults[$];
    bit          exp_instr[$];
    logic [VLEN-1:0] exp_vaddrs[$];
    int errors = 0, checks = 0, done_count = 0, cycles = 0;
    bit saw_imiss, saw_dmiss, saw_winstr;
    string       cmp_name;
    tlb_update_t cmp_update;
    bit          cmp_fault, cmp_instr;
    logic [VLEN-1:0] cmp_vaddr;

    page_table_walker #(.ASID_WIDTH(16)) dut0 (.*);

    bind page_table_walker page_table_walker_asserts u_asserts (.*);

    always #50 clk_i = !clk_i;

    // --------------------------------------------------
    // page tables and reference walk
    // --------------------------------------------------
    task automatic set_pte(logic [PPN_W-1:0] tbl, logic [8:0] idx, logic [PPN_W-1:0] ppn,
                           logic [7:0] flags);
        pt_mem[{tbl, idx, 3'b000}] = {10'b0, ppn, 2'b0, flags};
    endtask

    function automatic pte_t read_pte(logic [PLEN-1:0] addr);
        if (pt_mem.exists(addr)) return pte_t'(pt_mem[addr]);
        return '0;
    endfunction

    function automatic logic [VLEN-1:0] va(logic [8:0] v2, logic [8:0] v1, logic [8:0] v0);
        return {v2, v1, v0, 12'habc};
    endfunction

    // returns 1 for a page fault, else fills exp
    function automatic bit ref_walk(logic [VLEN-1:0] vaddr, bit instr, bit store, bit mxr,
                                    output tlb_update_t exp);
        logic [PLEN-1:0] pptr;
        pte_t pte;
        bit   glob;
        bit   perm;
        bit   mis;
        exp  = '0;
        glob = 1'b0;
        pptr = {satp_ppn_i, vaddr[38:30], 3'b000};
        for (int lvl = 0; lvl < 3; lvl++) begin
            pte  = read_pte(pptr);
            glob = glob | pte.g;
            if (!pte.v || (pte.w && !pte.r)) return 1'b1;
            if (!pte.r && !pte.x) begin
                if (lvl == 2) return 1'b1;
                pptr = {pte.ppn, (lvl == 0) ? vaddr[29:21] : vaddr[20:12], 3'b000};
            end else begin
                if (instr) perm = pte.x && pte.a;
                else perm = pte.a && (pte.r || (pte.x && mxr)) && (!store || (pte.w && pte.d));
                mis = (lvl == 0) ? (pte.ppn[17:0] != '0) : (lvl == 1) ? (pte.ppn[8:0] != '0) : 0;
                if (!perm || mis) return 1'b1;
                exp.valid     = 1'b1;
                exp.is_1g     = (lvl == 0);
                exp.is_2m     = (lvl == 1);
                exp.vpn       = vaddr[38:12];
                exp.asid      = asid_i;
                exp.content   = pte;
                exp.content.g = glob;
                return 1'b0;
            end
        end
        return 1'b1;
    endfunction

    // --------------------------------------------------
    // compare tasks and process
    // --------------------------------------------------
    task automatic check_update(string name, tlb_update_t exp, tlb_update_t act);
        checks++;
        if (exp !== act) begin
            errors++;
            $display("ERROR %s: expected %h actual %h", name, exp, act);
        end
    endtask

    task automatic check_error(string name, bit exp, bit act);
        checks++;
        if (exp !== act) begin
            errors++;
            $display("ERROR %s page fault: expected %0b actual %0b", name, exp, act);
        end
    endtask

    task automatic check_vaddr(string name, logic [VLEN-1:0] exp, logic [VLEN-1:0] act);
        checks++;
        if (exp !== act) begin
            errors++;
            $display("ERROR %s update vaddr: expected %h actual %h", name, exp, act);
        end
    endtask

    task automatic check_flag(string name, bit exp, bit act);
        checks++;
        if (exp !== act) begin
            errors++;
            $display("ERROR %s: expected %0b actual %0b", name, exp, act);
        end
    endtask

    always @(posedge clk_i) begin
        if (rst_ni && (itlb_update_o.valid || dtlb_update_o.valid || ptw_error_o)) begin
            if (exp_names.size() == 0) begin
                errors++;
                $display("walker reported a result while no walk was expected");
            end else begin
                cmp_name   = exp_names.pop_front();
                cmp_update = exp_updates.pop_front();
                cmp_fault  = exp_faults.pop_front();
                cmp_instr  = exp_instr.pop_front();
                cmp_vaddr  = exp_vaddrs.pop_front();
                check_error(cmp_name, cmp_fault, ptw_error_o);
                if (!cmp_fault) begin
                    check_update(cmp_name, cmp_update, cmp_instr ? itlb_update_o : dtlb_update_o);
                    check_vaddr(cmp_name, cmp_vaddr, update_vaddr_o);
                end
            end
            done_count++;
        end
        if (itlb_miss_o) saw_imiss = 1'b1;
        if (dtlb_miss_o) saw_dmiss = 1'b1;
        if (walking_instr_o && ptw_active_o) saw_winstr = 1'b1;
    end

    always @(posedge clk_i) begin
        cycles++;
        if (cycles > MAX_CYCLES) begin
            $display("timeout: walks did not finish within %0d cycles", MAX_CYCLES);
            $display("STATUS: FAIL");
            $finish;
        end
    end

    // --------------------------------------------------
    // memory model with grant after 0-3 cycles and data 1-3 later
    // --------------------------------------------------
    always begin
        logic [PLEN-1:0] addr;
        @(posedge clk_i);
        if (rst_ni && mem_req_o) begin
            repeat ($urandom_range(0, 3)) @(posedge clk_i);
            addr = mem_addr_o;
            mem_gnt_i <= 1'b1;
            @(posedge clk_i);
            mem_gnt_i <= 1'b0;
            repeat ($urandom_range(0, 2)) @(posedge clk_i);
            mem_rvalid_i <= 1'b1;
            mem_rdata_i  <= read_pte(addr);
            @(posedge clk_i);
            mem_rvalid_i <= 1'b0;
        end
    end

    // --------------------------------------------------
    // stimulus
    // --------------------------------------------------
    task automatic queue_expected(string name, bit instr, logic [VLEN-1:0] vaddr, bit store,
                                  bit mxr);
        tlb_update_t e;
        bit f;
        f = ref_walk(vaddr, instr, store, mxr, e);
        exp_names.push_back(name);
        exp_updates.push_back(e);
        exp_faults.push_back(f);
        exp_instr.push_back(instr);
        exp_vaddrs.push_back(vaddr);
    endtask

    task automatic present(bit ia, bit da, logic [VLEN-1:0] iva, logic [VLEN-1:0] dva,
                           bit store, bit mxr);
        saw_imiss  = 1'b0;
        saw_dmiss  = 1'b0;
        saw_winstr = 1'b0;
        @(posedge clk_i);
        lsu_is_store_i <= store;
        mxr_i          <= mxr;
        itlb_access_i  <= ia;
        itlb_vaddr_i   <= iva;
        dtlb_access_i  <= da;
        dtlb_vaddr_i   <= dva;
        @(posedge clk_i);
        itlb_access_i <= 1'b0;
        dtlb_access_i <= 1'b0;
    endtask

    task automatic wait_results(int target);
        while (done_count < target) @(posedge clk_i);
    endtask

    task automatic walk(string name, bit instr, logic [VLEN-1:0] vaddr, bit store, bit mxr);
        int target;
        target = done_count + 1;
        queue_expected(name, instr, vaddr, store, mxr);
        present(instr, !instr, vaddr, vaddr, store, mxr);
        wait_results(target);
    endtask

    initial begin
        void'($urandom(32'h5cfcfd9a));
        {rst_ni, flush_i, lsu_is_store_i, mxr_i, itlb_hit_i, dtlb_hit_i} = '0;
        {itlb_access_i, dtlb_access_i, mem_gnt_i, mem_rvalid_i} = '0;
        enable_translation_i   = 1'b1;
        en_ld_st_translation_i = 1'b1;
        satp_ppn_i   = ROOT;
        asid_i       = 16'h00a5;
        itlb_vaddr_i = '0;
        dtlb_vaddr_i = '0;
        mem_rdata_i  = '0;
        set_pte(ROOT, 9'd1, 44'h81, V);
        set_pte(ROOT, 9'd2, 44'h40000, V | R | W | A | D);
        set_pte(ROOT, 9'd3, 44'h83, V | G);
        set_pte(ROOT, 9'd5, 44'h99, V | W);
        set_pte(44'h81, 9'd1, 44'h82, V);
        set_pte(44'h81, 9'd2, 44'h400, V | R | W | A | D);
        set_pte(44'h81, 9'd3, 44'h401, V | R | A);
        set_pte(44'h83, 9'd0, 44'h600, V | R | A);
        set_pte(44'h82, 9'd1, 44'h1234, V | R | W | X | A | D);
        set_pte(44'h82, 9'd2, 44'h1235, V);
        set_pte(44'h82, 9'd3, 44'h1236, V | R | A);
        set_pte(44'h82, 9'd4, 44'h1237, V | R | W | A);
        set_pte(44'h82, 9'd5, 44'h1238, V | X | A);
        repeat (8) @(posedge clk_i);
        rst_ni <= 1'b1;

        walk("instr 4k", 1, va(1, 1, 1), 0, 0);
        check_flag("itlb miss strobe", 1, saw_imiss);
        check_flag("walking instr", 1, saw_winstr);
        walk("load 1g", 0, va(2, 5, 7), 0, 0);
        walk("store 2m", 0, va(1, 2, 9), 1, 0);
        walk("global from pointer", 0, va(3, 0, 4), 0, 0);
        walk("invalid entry", 0, va(4, 0, 0), 0, 0);
        walk("write only", 0, va(5, 0, 0), 0, 0);
        walk("pointer at lvl3", 0, va(1, 1, 2), 0, 0);
        walk("misaligned 2m", 0, va(1, 3, 0), 0, 0);
        walk("instr without x", 1, va(1, 1, 3), 0, 0);
        walk("store clean page", 0, va(1, 1, 4), 1, 0);
        walk("exec only no mxr", 0, va(1, 1, 5), 0, 0);
        walk("exec only mxr", 0, va(1, 1, 5), 0, 1);

        // both TLBs miss together
        queue_expected("both data", 0, va(2, 1, 1), 0, 0);
        present(1, 1, va(1, 1, 1), va(2, 1, 1), 0, 0);
        wait_results(done_count + 1);
        check_flag("data miss first", 1, saw_dmiss);
        check_flag("instr miss held", 0, saw_imiss);
        walk("both instr", 1, va(1, 1, 1), 0, 0);

        // flush in the middle of a walk
        present(0, 1, '0, va(1, 1, 1), 0, 0);
        while (!mem_req_o) @(posedge clk_i);
        @(posedge clk_i);
        flush_i <= 1'b1;
        @(posedge clk_i);
        flush_i <= 1'b0;
        while (ptw_active_o) @(posedge clk_i);
        repeat (10) @(posedge clk_i);
        check_flag("active after flush", 0, ptw_active_o);
        walk("after flush", 0, va(1, 1, 1), 0, 0);

        $display("checks: %0d errors: %0d", checks, errors);
        if (errors == 0 && exp_names.size() == 0) begin
            $display("STATUS: PASS");
        end else begin
            $display("STATUS: FAIL");
        end
        $finish;
    end

endmodule

//--- verilog.f
logic/ptw_pkg.sv
logic/walk_req_if.sv
logic/tlb_miss_arbiter.sv
logic/pte_checker.sv
logic/walk_controller.sv
logic/page_table_walker.sv
bench/page_table_walker_asserts.sv
bench/tb_page_table_walker.sv

//--- run_sim.sh
#!/usr/bin/env bash
# build and run the page table walker testbench with Verilator
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert \
    --top-module tb_page_table_walker \
    -f verilog.f

out=$(./obj_dir/Vtb_page_table_walker)
echo "$out"
grep -q "^STATUS: PASS$" <<< "$out"
